// File: hw/riscv_pkg.sv
package riscv_pkg;

    // major opcodes of the supported RV32I subset
    typedef enum logic [6:0] {
        op_load   = 7'b0000011,            // lw
        op_imm    = 7'b0010011,            // addi
        op_store  = 7'b0100011,            // sw
        op_reg    = 7'b0110011,            // add sub and or xor
        op_branch = 7'b1100011,            // beq
        op_jal    = 7'b1101111             // jal
    } opcode_e;

    typedef enum logic [2:0] {
        alu_op_add = 3'd0,
        alu_op_sub = 3'd1,                 // also used for beq compare
        alu_op_and = 3'd2,
        alu_op_or  = 3'd3,
        alu_op_xor = 3'd4
    } alu_op_e;

    typedef enum logic {
        alu_src_reg = 1'b0,                // operand b from rs2
        alu_src_imm = 1'b1                 // operand b from extended imm
    } alu_src_e;

    typedef enum logic [1:0] {
        res_src_alu = 2'd0,                // alu result
        res_src_mem = 2'd1,                // load data
        res_src_pc4 = 2'd2                 // link value for jal
    } result_src_e;

    typedef enum logic {
        pc_src_plus_4   = 1'b0,
        pc_src_plus_off = 1'b1             // pc + imm, taken beq or jal
    } pc_src_e;

    typedef enum logic [1:0] {
        imm_i = 2'd0,
        imm_s = 2'd1,
        imm_b = 2'd2,
        imm_j = 2'd3
    } imm_src_e;

    // decoded control word, controller to datapath
    typedef struct packed {
        logic        reg_we;
        logic        mem_we;
        alu_src_e    alu_src;
        result_src_e result_src;
        pc_src_e     pc_src;
        imm_src_e    imm_src;
        alu_op_e     alu_ctrl;
    } ctrl_t;

    // one retired instruction as seen at the top level
    typedef struct packed {
        logic [31:0] pc;
        logic        reg_we;               // never set for rd == x0
        logic [4:0]  rd;
        logic [31:0] reg_data;
        logic        mem_we;
        logic [31:0] mem_addr;
        logic [31:0] mem_data;
    } trace_t;

endpackage

// File: hw/alu.sv
`timescale 1ns/1ps

module alu (
    input  logic [31:0]        a,
    input  logic [31:0]        b,
    input  riscv_pkg::alu_op_e op,
    output logic [31:0]        y,
    output logic               zero
);
    logic [31:0] sum;                          // a + b
    logic [31:0] diff;                         // a - b

    assign sum  = a + b;
    assign diff = a - b;

    always_comb begin
        case (op)
            riscv_pkg::alu_op_add: y = sum;
            riscv_pkg::alu_op_sub: y = diff;
            riscv_pkg::alu_op_and: y = a & b;
            riscv_pkg::alu_op_or:  y = a | b;
            riscv_pkg::alu_op_xor: y = a ^ b;
            default:               y = sum;    // unused encodings
        endcase
    end

    // beq relies on this with op = sub
    assign zero = (y == 32'd0);

endmodule

// File: hw/reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        we,
    input  logic [4:0]  ra1,
    input  logic [4:0]  ra2,
    input  logic [4:0]  wa,
    input  logic [31:0] wd,
    output logic [31:0] rd1,
    output logic [31:0] rd2
);
    logic [31:0] regs [32];                    // x0..x31

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (we && (wa != 5'd0)) begin // x0 stays zero
            regs[wa] <= wd;
        end
    end

    // async read, new value visible after the edge
    assign rd1 = regs[ra1];
    assign rd2 = regs[ra2];

endmodule

// File: hw/imm_extend.sv
`timescale 1ns/1ps

module imm_extend (
    input  logic [31:0]         instr,
    input  riscv_pkg::imm_src_e imm_src,
    output logic [31:0]         imm
);
    always_comb begin
        case (imm_src)
            riscv_pkg::imm_i: imm = {{20{instr[31]}}, instr[31:20]};
            riscv_pkg::imm_s: imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            riscv_pkg::imm_b: begin                     // bit 0 implied zero
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                       instr[11:8], 1'b0};
            end
            default: begin                              // j-type, +-1 MiB range
                imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                       instr[30:21], 1'b0};
            end
        endcase
    end
endmodule

// File: hw/controller.sv
`timescale 1ns/1ps

module alu_dec (
    input  riscv_pkg::opcode_e op,
    input  logic [2:0]         func3,
    input  logic [6:0]         func7,
    output riscv_pkg::alu_op_e alu_ctrl
);
    riscv_pkg::alu_op_e r_type_ctrl;           // op chosen by func3/func7

    always_comb begin
        case (func3)
            3'b000: begin
                if (func7[5]) begin                // 0100000 -> sub
                    r_type_ctrl = riscv_pkg::alu_op_sub;
                end else begin
                    r_type_ctrl = riscv_pkg::alu_op_add;
                end
            end
            3'b100:  r_type_ctrl = riscv_pkg::alu_op_xor;
            3'b110:  r_type_ctrl = riscv_pkg::alu_op_or;
            3'b111:  r_type_ctrl = riscv_pkg::alu_op_and;
            default: r_type_ctrl = riscv_pkg::alu_op_add;   // unsupported funct, harmless
        endcase
    end

    always_comb begin
        case (op)
            riscv_pkg::op_reg:    alu_ctrl = r_type_ctrl;
            riscv_pkg::op_imm:    alu_ctrl = riscv_pkg::alu_op_add;   // addi
            riscv_pkg::op_load:   alu_ctrl = riscv_pkg::alu_op_add;   // rs1 + imm
            riscv_pkg::op_store:  alu_ctrl = riscv_pkg::alu_op_add;   // rs1 + imm
            riscv_pkg::op_branch: alu_ctrl = riscv_pkg::alu_op_sub;   // zero on equal
            default:              alu_ctrl = riscv_pkg::alu_op_add;
        endcase
    end
endmodule

module controller (
    input  logic [31:0]      instr,
    input  logic             alu_zero,
    output riscv_pkg::ctrl_t ctrl
);
    riscv_pkg::opcode_e op;
    riscv_pkg::alu_op_e alu_ctrl;
    riscv_pkg::pc_src_e pc_src_beq;            // resolved branch target select

    assign op = riscv_pkg::opcode_e'(instr[6:0]);
    assign pc_src_beq = alu_zero ? riscv_pkg::pc_src_plus_off : riscv_pkg::pc_src_plus_4;

    alu_dec ad (
        .op       (op),
        .func3    (instr[14:12]),
        .func7    (instr[31:25]),
        .alu_ctrl (alu_ctrl)
    );

    always_comb begin
        ctrl.reg_we     = 1'b0;                // safe values, unknown opcode
        ctrl.mem_we     = 1'b0;
        ctrl.alu_src    = riscv_pkg::alu_src_reg;
        ctrl.result_src = riscv_pkg::res_src_alu;
        ctrl.pc_src     = riscv_pkg::pc_src_plus_4;
        ctrl.imm_src    = riscv_pkg::imm_i;
        ctrl.alu_ctrl   = alu_ctrl;
        case (op)
            riscv_pkg::op_load: begin
                ctrl.reg_we     = 1'b1;
                ctrl.alu_src    = riscv_pkg::alu_src_imm;
                ctrl.result_src = riscv_pkg::res_src_mem;   // rd <- mem[rs1 + imm]
            end
            riscv_pkg::op_imm: begin
                ctrl.reg_we     = 1'b1;
                ctrl.alu_src    = riscv_pkg::alu_src_imm;
            end
            riscv_pkg::op_store: begin
                ctrl.mem_we     = 1'b1;
                ctrl.alu_src    = riscv_pkg::alu_src_imm;
                ctrl.imm_src    = riscv_pkg::imm_s;         // split imm field
            end
            riscv_pkg::op_reg: begin
                ctrl.reg_we     = 1'b1;                     // both operands from regs
            end
            riscv_pkg::op_branch: begin
                ctrl.pc_src     = pc_src_beq;               // taken only on equal
                ctrl.imm_src    = riscv_pkg::imm_b;
            end
            riscv_pkg::op_jal: begin
                ctrl.reg_we     = 1'b1;
                ctrl.result_src = riscv_pkg::res_src_pc4;   // link
                ctrl.pc_src     = riscv_pkg::pc_src_plus_off;
                ctrl.imm_src    = riscv_pkg::imm_j;
            end
            default: ;                                      // keep safe values
        endcase
    end
endmodule

// File: hw/datapath.sv
`timescale 1ns/1ps

module datapath (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              run,
    input  logic [31:0]       instr,
    input  riscv_pkg::ctrl_t  ctrl,
    input  logic [31:0]       mem_rdata,
    output logic [31:0]       pc,
    output logic [31:0]       mem_addr,
    output logic [31:0]       mem_wdata,
    output logic              mem_we,
    output logic              alu_zero,
    output riscv_pkg::trace_t trace
);
    logic [31:0] pc_plus4;
    logic [31:0] pc_target;
    logic [31:0] pc_next;
    logic [31:0] imm;
    logic [31:0] rd1;
    logic [31:0] rd2;
    logic [31:0] src_b;
    logic [31:0] alu_y;
    logic [31:0] result;                       // writeback value
    logic        reg_we;                       // write enable after run gating

    assign pc_plus4  = pc + 32'd4;
    assign pc_target = pc + imm;               // branch and jal share this adder
    assign pc_next   = (ctrl.pc_src == riscv_pkg::pc_src_plus_off) ? pc_target : pc_plus4;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= 32'd0;
        end else if (run) begin                // hold while stopped
            pc <= pc_next;
        end
    end

    assign reg_we = ctrl.reg_we & run;
    assign mem_we = ctrl.mem_we & run;

    reg_file rf (
        .clk    (clk),
        .arst_n (arst_n),
        .we     (reg_we),
        .ra1    (instr[19:15]),
        .ra2    (instr[24:20]),
        .wa     (instr[11:7]),
        .wd     (result),
        .rd1    (rd1),
        .rd2    (rd2)
    );

    imm_extend ext (
        .instr   (instr),
        .imm_src (ctrl.imm_src),
        .imm     (imm)
    );

    assign src_b = (ctrl.alu_src == riscv_pkg::alu_src_imm) ? imm : rd2;

    alu alu0 (
        .a    (rd1),
        .b    (src_b),
        .op   (ctrl.alu_ctrl),
        .y    (alu_y),
        .zero (alu_zero)
    );

    always_comb begin
        case (ctrl.result_src)
            riscv_pkg::res_src_mem: result = mem_rdata;
            riscv_pkg::res_src_pc4: result = pc_plus4;
            default:                result = alu_y;
        endcase
    end

    assign mem_addr  = alu_y;                  // byte address, word aligned by sw
    assign mem_wdata = rd2;

    always_comb begin
        trace.pc       = pc;
        trace.reg_we   = reg_we & (instr[11:7] != 5'd0);   // hide x0 writes
        trace.rd       = instr[11:7];
        trace.reg_data = result;
        trace.mem_we   = mem_we;
        trace.mem_addr = alu_y;
        trace.mem_data = rd2;
    end
endmodule

// File: hw/instr_mem.sv
`timescale 1ns/1ps

module instr_mem #(
    parameter int IMEM_WORDS = 256
) (
    input  logic        clk,
    input  logic        prog_we,
    input  logic [31:0] prog_addr,
    input  logic [31:0] prog_data,
    input  logic [31:0] pc,
    output logic [31:0] instr
);
    localparam int AW = $clog2(IMEM_WORDS);   // word index width

    logic [31:0] mem [IMEM_WORDS];

    // load port, byte address like the pc
    always_ff @(posedge clk) begin
        if (prog_we) begin
            mem[prog_addr[AW+1:2]] <= prog_data;
        end
    end

    assign instr = mem[pc[AW+1:2]];            // async fetch, upper bits alias

endmodule

// File: hw/data_mem.sv
`timescale 1ns/1ps

module data_mem #(
    parameter int DMEM_WORDS = 256
) (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        we,
    input  logic [31:0] addr,
    input  logic [31:0] wdata,
    output logic [31:0] rdata
);
    localparam int AW = $clog2(DMEM_WORDS);   // word index width

    logic [31:0] mem [DMEM_WORDS];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < DMEM_WORDS; i++) begin
                mem[i] <= 32'd0;               // loads before any store read 0
            end
        end else if (we) begin
            mem[addr[AW+1:2]] <= wdata;        // byte offset bits ignored
        end
    end

    assign rdata = mem[addr[AW+1:2]];          // async read for single cycle lw

endmodule

// File: hw/riscv_core_top.sv
`timescale 1ns/1ps

module riscv_core_top #(
    parameter int IMEM_WORDS = 256,
    parameter int DMEM_WORDS = 256
) (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              run,
    input  logic              prog_we,
    input  logic [31:0]       prog_addr,
    input  logic [31:0]       prog_data,
    output riscv_pkg::trace_t trace,
    output logic              trace_valid
);
    logic [31:0]      instr;
    logic [31:0]      pc;
    logic [31:0]      mem_addr;
    logic [31:0]      mem_wdata;
    logic [31:0]      mem_rdata;
    logic             mem_we;                  // already gated by run
    logic             alu_zero;
    riscv_pkg::ctrl_t ctrl;

    controller ctl (.instr(instr), .alu_zero(alu_zero), .ctrl(ctrl));

    datapath dp (
        .clk       (clk),
        .arst_n    (arst_n),
        .run       (run),
        .instr     (instr),
        .ctrl      (ctrl),
        .mem_rdata (mem_rdata),
        .pc        (pc),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_we    (mem_we),
        .alu_zero  (alu_zero),
        .trace     (trace)
    );

    instr_mem #(.IMEM_WORDS(IMEM_WORDS)) imem (
        .clk       (clk),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .pc        (pc),
        .instr     (instr)
    );

    data_mem #(.DMEM_WORDS(DMEM_WORDS)) dmem (
        .clk    (clk),
        .arst_n (arst_n),
        .we     (mem_we),
        .addr   (mem_addr),
        .wdata  (mem_wdata),
        .rdata  (mem_rdata)
    );

    assign trace_valid = run;                  // one retirement per running cycle

endmodule

// File: verification/core_asserts.sv
`timescale 1ns/1ps

module core_asserts (
    input logic              clk,
    input logic              arst_n,
    input logic              run,
    input logic [31:0]       pc,
    input logic              mem_we,
    input riscv_pkg::trace_t trace
);
    int fail_count = 0;                        // summed into the tb verdict

    no_dual_write: assert property (@(posedge clk) disable iff (!arst_n)
        !(trace.reg_we && trace.mem_we))
    else begin
        fail_count++;
        $error("register and memory write retired in the same cycle");
    end

    pc_aligned: assert property (@(posedge clk) disable iff (!arst_n)
        pc[1:0] == 2'b00)
    else begin
        fail_count++;
        $error("pc not word aligned");
    end

    // run sampled at the edge gates the pc update at that edge
    pc_hold_idle: assert property (@(posedge clk) disable iff (!arst_n)
        !run |=> $stable(pc))
    else begin
        fail_count++;
        $error("pc changed while run was low");
    end

    no_write_in_reset: assert property (@(posedge clk)
        !arst_n |-> (!mem_we && !trace.reg_we))
    else begin
        fail_count++;
        $error("write enable active during reset");
    end

endmodule

bind riscv_core_top core_asserts asrt (
    .clk    (clk),
    .arst_n (arst_n),
    .run    (run),
    .pc     (pc),
    .mem_we (mem_we),
    .trace  (trace)
);

// File: verification/core_tb.sv
`timescale 1ns/1ps

module core_tb;
    localparam int CLK_PERIOD = 4;             // ns

    logic              clk;
    logic              arst_n;
    logic              run;
    logic              prog_we;
    logic [31:0]       prog_addr;
    logic [31:0]       prog_data;
    riscv_pkg::trace_t trace;
    logic              trace_valid;

    logic [31:0] p_addr [$];                   // program image from P lines
    logic [31:0] p_word [$];
    logic [31:0] w_rd   [$];                   // expected reg writes, in order
    logic [31:0] w_val  [$];
    logic [31:0] m_addr [$];                   // expected stores, in order
    logic [31:0] m_val  [$];

    int          w_idx;
    int          m_idx;
    int          checks;
    int          errors;
    bit          halted;                       // final jal-to-self retired
    bit          started;                      // arms the watchdog
    logic [31:0] halt_pc;
    logic [31:0] prev_pc;
    logic        prev_valid;

    riscv_core_top #(.IMEM_WORDS(256), .DMEM_WORDS(256)) dut0 (
        .clk         (clk),
        .arst_n      (arst_n),
        .run         (run),
        .prog_we     (prog_we),
        .prog_addr   (prog_addr),
        .prog_data   (prog_data),
        .trace       (trace),
        .trace_valid (trace_valid)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic read_testdata();
        int          fd;
        int          n;
        string       line;
        logic [7:0]  kind;
        logic [31:0] a;
        logic [31:0] b;
        fd = $fopen("verification/core_testdata.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open verification/core_testdata.txt");
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n <= 1 || line[0] == "#") continue;      // blank or comment
            n = $sscanf(line, "%c %h %h", kind, a, b);
            if (n != 3) continue;
            case (kind)
                "P": begin
                    p_addr.push_back(a);
                    p_word.push_back(b);
                end
                "W": begin
                    w_rd.push_back(a);
                    w_val.push_back(b);
                end
                "M": begin
                    m_addr.push_back(a);
                    m_val.push_back(b);
                end
                default: begin
                    errors++;
                    $display("test data line of unknown kind: %s", line);
                end
            endcase
        end
        $fclose(fd);
    endtask

    task automatic load_program();
        foreach (p_addr[i]) begin
            @(posedge clk);
            #1;
            prog_we   = 1'b1;
            prog_addr = p_addr[i];
            prog_data = p_word[i];
        end
        @(posedge clk);
        #1;
        prog_we = 1'b0;                        // last word taken at that edge
    endtask

    // sampled at negedge, inputs settled since posedge + 1
    task automatic check_trace();
        string name;
        if (prev_valid === 1'b0) begin         // edge in between ran with run low
            checks++;
            assert (trace.pc == prev_pc) else begin
                errors++;
                $display("[ERROR] idle_hold: pc expected 0x%08h, actual 0x%08h",
                         prev_pc, trace.pc);
            end
        end
        if (!trace_valid) begin
            checks++;
            assert (!trace.reg_we && !trace.mem_we) else begin
                errors++;
                $display("write event seen while run was low, pc 0x%08h", trace.pc);
            end
        end
        if (trace_valid && trace.reg_we) begin
            name = $sformatf("reg_write %0d", w_idx);
            if (w_idx >= w_rd.size()) begin
                errors++;
                $display("unexpected register write to x%0d at pc 0x%08h",
                         trace.rd, trace.pc);
            end else begin
                checks += 2;
                assert (trace.rd == w_rd[w_idx][4:0]) else begin
                    errors++;
                    $display("[ERROR] %s: rd expected x%0d, actual x%0d",
                             name, w_rd[w_idx][4:0], trace.rd);
                end
                assert (trace.reg_data == w_val[w_idx]) else begin
                    errors++;
                    $display("[ERROR] %s: data expected 0x%08h, actual 0x%08h",
                             name, w_val[w_idx], trace.reg_data);
                end
                w_idx++;
            end
        end
        if (trace_valid && trace.mem_we) begin
            name = $sformatf("mem_write %0d", m_idx);
            if (m_idx >= m_addr.size()) begin
                errors++;
                $display("unexpected store to 0x%08h at pc 0x%08h",
                         trace.mem_addr, trace.pc);
            end else begin
                checks += 2;
                assert (trace.mem_addr == m_addr[m_idx]) else begin
                    errors++;
                    $display("[ERROR] %s: addr expected 0x%08h, actual 0x%08h",
                             name, m_addr[m_idx], trace.mem_addr);
                end
                assert (trace.mem_data == m_val[m_idx]) else begin
                    errors++;
                    $display("[ERROR] %s: data expected 0x%08h, actual 0x%08h",
                             name, m_val[m_idx], trace.mem_data);
                end
                m_idx++;
            end
        end
        if (trace_valid && trace.pc == halt_pc) halted = 1'b1;
        prev_pc    = trace.pc;
        prev_valid = trace_valid;
    endtask

    task automatic run_program();
        prev_valid = 1'b1;                     // nothing to compare on first cycle
        prev_pc    = trace.pc;
        while (!halted) begin
            @(posedge clk);
            #1;
            run = ($urandom % 5 != 0);         // roughly one idle cycle in five
            @(negedge clk);
            check_trace();
        end
        @(posedge clk);
        #1;
        run = 1'b0;
    endtask

    initial begin
        arst_n    = 1'b0;
        run       = 1'b0;
        prog_we   = 1'b0;
        prog_addr = 32'd0;
        prog_data = 32'd0;
        checks    = 0;
        errors    = 0;
        w_idx     = 0;
        m_idx     = 0;
        halted    = 1'b0;
        started   = 1'b0;
        void'($urandom(21));
        read_testdata();
        repeat (2) @(posedge clk);
        #1;
        arst_n = 1'b1;
        if (p_addr.size() == 0) begin
            errors++;
            $display("test data holds no program words, nothing was run");
        end else begin
            halt_pc = p_addr[p_addr.size() - 1];   // last word is the jal-to-self
            started = 1'b1;
            load_program();
            run_program();
            checks++;
            assert (w_idx == w_rd.size() && m_idx == m_addr.size()) else begin
                errors++;
                $display("program ended with %0d register and %0d store writes missing",
                         w_rd.size() - w_idx, m_addr.size() - m_idx);
            end
        end
        $display("checks: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, dut0.asrt.fail_count);
        if (errors == 0 && dut0.asrt.fail_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // limit scales with program length
    initial begin
        wait (started);
        #(CLK_PERIOD * (p_addr.size() * 20 + 200));
        errors++;
        $display("timeout: the program did not reach its final jump in time");
        $display("checks: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, dut0.asrt.fail_count);
        $display("Done: errors found");
        $finish;
    end

endmodule

// File: verification/core_testdata.txt
# P <byte addr> <instr word> | W <rd> <value> | M <byte addr> <value>, all hex
# W and M lines are in retire order, the last P line is the final jal-to-self
P 00 00500093  # addi x1, x0, 5
P 04 00c00113  # addi x2, x0, 12
P 08 002081b3  # add  x3, x1, x2
P 0c 40110233  # sub  x4, x2, x1
P 10 0020f2b3  # and  x5, x1, x2
P 14 0020e333  # or   x6, x1, x2
P 18 0020c3b3  # xor  x7, x1, x2
P 1c 00308013  # addi x0, x1, 3   no event
P 20 00100433  # add  x8, x0, x1  x0 reads 0
P 24 00312423  # sw   x3, 8(x2)
P 28 00812483  # lw   x9, 8(x2)
P 2c 00808463  # beq  x1, x8, +8  taken
P 30 00100513  # addi x10, x0, 1  skipped
P 34 00208463  # beq  x1, x2, +8  not taken
P 38 fff00593  # addi x11, x0, -1
P 3c 0080066f  # jal  x12, +8
P 40 00700693  # addi x13, x0, 7  skipped
P 44 40100733  # sub  x14, x0, x1
P 48 0000006f  # jal  x0, 0
W 01 00000005
W 02 0000000c
W 03 00000011
W 04 00000007
W 05 00000004
W 06 0000000d
W 07 00000009
W 08 00000005
M 14 00000011
W 09 00000011
W 0b ffffffff
W 0c 00000040
W 0e fffffffb

// File: build.f
hw/riscv_pkg.sv
hw/alu.sv
hw/reg_file.sv
hw/imm_extend.sv
hw/controller.sv
hw/datapath.sv
hw/instr_mem.sv
hw/data_mem.sv
hw/riscv_core_top.sv
verification/core_asserts.sv
verification/core_tb.sv
